//--- Bender.yml
package:
  name: rom_3slots

sources:
  - logic/rom_geom_pkg.sv
  - logic/rom_types_pkg.sv
  - logic/slot_rd_if.sv
  - logic/rom_slot.sv
  - logic/rom_arbiter.sv
  - logic/rom_3slots.sv
  - target: test
    files:
      - test/sdram_model.sv
      - test/tb_rom_3slots.sv

//--- logic/rom_3slots.sv
// top level of the three-slot read-only ROM port, placed between the console core and the SDRAM controller
`timescale 1ns/1ps
`default_nettype none

module rom_3slots #(
    parameter int                  SDRAM_AW     = rom_geom_pkg::sdram_aw,
    parameter int                  SLOT0_AW     = 8,
    parameter int                  SLOT1_AW     = 8,
    parameter int                  SLOT2_AW     = 8,
    parameter logic [SDRAM_AW-1:0] SLOT0_OFFSET = '0,
    parameter logic [SDRAM_AW-1:0] SLOT1_OFFSET = '0,
    parameter logic [SDRAM_AW-1:0] SLOT2_OFFSET = '0,
    parameter type                 slot0_t      = logic [7:0],
    parameter type                 slot1_t      = logic [7:0],
    parameter type                 slot2_t      = logic [7:0]
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire [SLOT0_AW-1:0]              slot0_addr,
    input  wire                             slot0_cs,
    output wire slot0_t                     slot0_dout,
    output wire                             slot0_ok,
    input  wire [SLOT1_AW-1:0]              slot1_addr,
    input  wire                             slot1_cs,
    output wire slot1_t                     slot1_dout,
    output wire                             slot1_ok,
    input  wire [SLOT2_AW-1:0]              slot2_addr,
    input  wire                             slot2_cs,
    output wire slot2_t                     slot2_dout,
    output wire                             slot2_ok,
    // SDRAM controller side
    output wire                             sdram_req,
    output wire [SDRAM_AW-1:0]              sdram_addr,
    input  wire                             sdram_ack,
    input  wire                             data_rdy,
    input  wire rom_types_pkg::sdram_word_t data_read
);

    slot_rd_if #(.addr_w(SDRAM_AW)) slot0_bus ();
    slot_rd_if #(.addr_w(SDRAM_AW)) slot1_bus ();
    slot_rd_if #(.addr_w(SDRAM_AW)) slot2_bus ();

    rom_slot #(
        .data_t   (slot0_t),
        .addr_w   (SLOT0_AW),
        .sdram_aw (SDRAM_AW),
        .offset   (SLOT0_OFFSET)
    ) u_slot0 (
        .clk  (clk),
        .rst  (rst),
        .addr (slot0_addr),
        .cs   (slot0_cs),
        .dout (slot0_dout),
        .ok   (slot0_ok),
        .bus  (slot0_bus.client)
    );

    rom_slot #(
        .data_t   (slot1_t),
        .addr_w   (SLOT1_AW),
        .sdram_aw (SDRAM_AW),
        .offset   (SLOT1_OFFSET)
    ) u_slot1 (
        .clk  (clk),
        .rst  (rst),
        .addr (slot1_addr),
        .cs   (slot1_cs),
        .dout (slot1_dout),
        .ok   (slot1_ok),
        .bus  (slot1_bus.client)
    );

    rom_slot #(
        .data_t   (slot2_t),
        .addr_w   (SLOT2_AW),
        .sdram_aw (SDRAM_AW),
        .offset   (SLOT2_OFFSET)
    ) u_slot2 (
        .clk  (clk),
        .rst  (rst),
        .addr (slot2_addr),
        .cs   (slot2_cs),
        .dout (slot2_dout),
        .ok   (slot2_ok),
        .bus  (slot2_bus.client)
    );

    rom_arbiter #(
        .sdram_aw (SDRAM_AW)
    ) u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .slot0      (slot0_bus.server),
        .slot1      (slot1_bus.server),
        .slot2      (slot2_bus.server),
        .sdram_req  (sdram_req),
        .sdram_addr (sdram_addr),
        .sdram_ack  (sdram_ack),
        .data_rdy   (data_rdy),
        .data_read  (data_read)
    );

endmodule

`default_nettype wire

//--- logic/rom_arbiter.sv
// fixed-priority owner of the single SDRAM read channel, shared by the three slots of the ROM port
`timescale 1ns/1ps
`default_nettype none

module rom_arbiter #(
    parameter int sdram_aw = rom_geom_pkg::sdram_aw
) (
    input  wire                             clk,
    input  wire                             rst,
    slot_rd_if.server                       slot0,
    slot_rd_if.server                       slot1,
    slot_rd_if.server                       slot2,
    output logic                            sdram_req,
    output logic [sdram_aw-1:0]             sdram_addr,
    input  wire                             sdram_ack,
    input  wire                             data_rdy,
    input  wire rom_types_pkg::sdram_word_t data_read
);
    import rom_geom_pkg::*;
    import rom_types_pkg::*;

    slot_sel_t           req_vec;
    slot_sel_t           owner;
    slot_sel_t           active;
    slot_sel_t           grant;
    logic [sdram_aw-1:0] slot_addr [n_slots];
    logic [sdram_aw-1:0] grant_addr;
    logic                load;

    assign req_vec      = {slot2.req, slot1.req, slot0.req};
    assign slot_addr[0] = slot0.addr;
    assign slot_addr[1] = slot1.addr;
    assign slot_addr[2] = slot2.addr;

    // the owner still holds req during its data_rdy cycle
    assign active = req_vec & ~owner;
    assign load   = (owner == '0) || data_rdy;

    // lowest index wins
    always_comb begin
        grant      = '0;
        grant_addr = '0;
        for (int i = 0; i < n_slots; i++) begin
            if (active[i] && (grant == '0)) begin
                grant[i]   = 1'b1;
                grant_addr = slot_addr[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sdram_req <= 1'b0;
            owner     <= '0;
        end else if (load) begin
            sdram_req <= |active;
            owner     <= grant;
        end else if (sdram_ack) begin
            sdram_req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load && |active) begin
            sdram_addr <= grant_addr;
        end
    end

    // read data goes to every slot, only the owner sees we
    assign slot0.data = data_read;
    assign slot1.data = data_read;
    assign slot2.data = data_read;
    assign slot0.rdy  = data_rdy;
    assign slot1.rdy  = data_rdy;
    assign slot2.rdy  = data_rdy;
    assign slot0.we   = owner[0];
    assign slot1.we   = owner[1];
    assign slot2.we   = owner[2];

endmodule

`default_nettype wire

//--- logic/rom_geom_pkg.sv
// address and word geometry of the SDRAM and the client slots, imported by the ROM port and its testbench
`default_nettype none

package rom_geom_pkg;

    // default SDRAM word-address width
    localparam int sdram_aw = 22;

    // one SDRAM read returns a word of this many bits
    localparam int sdram_dw = 32;

    // client slots sharing the read channel, slot 0 has top priority
    localparam int n_slots = 3;

    // log2 of the number of items that fit in one SDRAM word
    // item addresses are shifted right by this to get the word address
    function automatic int item_shift(input int item_w);
        return $clog2(sdram_dw / item_w);
    endfunction

endpackage

`default_nettype wire

//--- logic/rom_slot.sv
// client slot of the ROM port with a one-word cache, instantiated once per slot by the top level
`timescale 1ns/1ps
`default_nettype none

module rom_slot #(
    parameter type                 data_t   = logic [7:0],
    parameter int                  addr_w   = 8,
    parameter int                  sdram_aw = rom_geom_pkg::sdram_aw,
    parameter logic [sdram_aw-1:0] offset   = '0
) (
    input  wire              clk,
    input  wire              rst,
    input  wire [addr_w-1:0] addr,
    input  wire              cs,
    output data_t            dout,
    output logic             ok,
    slot_rd_if.client        bus
);
    import rom_geom_pkg::*;
    import rom_types_pkg::*;

    localparam int item_w  = $bits(data_t);
    localparam int shift_w = item_shift(item_w);

    logic [sdram_aw-1:0] word_addr;
    logic                hit;
    logic                miss;
    data_t               item;

    // cached word and its tag
    sdram_word_t         cache_word;
    logic [sdram_aw-1:0] tag;
    logic                valid;

    // request waiting for the arbiter and the SDRAM
    logic                pending;
    logic [sdram_aw-1:0] req_addr;

    // previous cycle's inputs, ok needs a stable address
    logic [addr_w-1:0]   addr_q;
    logic                cs_q;

    assign word_addr = offset + sdram_aw'(addr >> shift_w);
    assign hit       = valid && (tag == word_addr);
    assign miss      = cs && !hit && !pending;

    // item 0 sits in the least significant bits of the word
    if (shift_w > 0) begin : g_sel
        assign item = cache_word[addr[shift_w-1:0] * item_w +: item_w];
    end else begin : g_word
        assign item = cache_word;
    end

    assign bus.req  = pending;
    assign bus.addr = req_addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid   <= 1'b0;
            pending <= 1'b0;
            cs_q    <= 1'b0;
            ok      <= 1'b0;
        end else begin
            cs_q <= cs;
            ok   <= cs && cs_q && (addr == addr_q) && hit;
            if (bus.rdy && bus.we) begin
                valid   <= 1'b1;
                pending <= 1'b0;
            end else if (miss) begin
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= addr;
        dout   <= item;
        // the tag is the address sent out, even if addr moved on since
        if (bus.rdy && bus.we) begin
            cache_word <= bus.data;
            tag        <= req_addr;
        end
        if (miss) begin
            req_addr <= word_addr;
        end
    end

endmodule

`default_nettype wire

//--- logic/rom_types_pkg.sv
// data and select types of the ROM port, imported by the RTL and the SDRAM model
`default_nettype none

package rom_types_pkg;

    // one word as returned by the SDRAM on data_read
    typedef logic [rom_geom_pkg::sdram_dw-1:0] sdram_word_t;

    // one-hot owner of the outstanding SDRAM read, bit n for slot n
    typedef logic [rom_geom_pkg::n_slots-1:0] slot_sel_t;

endpackage

`default_nettype wire

//--- logic/slot_rd_if.sv
// read channel of one slot, instantiated per slot between the slot and the arbiter
`timescale 1ns/1ps
`default_nettype none

interface slot_rd_if #(
    parameter int addr_w = rom_geom_pkg::sdram_aw
) ();
    import rom_types_pkg::*;

    // level, held while the slot cache misses
    logic              req;
    // SDRAM word address, steady while req is high
    logic [addr_w-1:0] addr;
    // high while this slot owns the outstanding read
    logic              we;
    sdram_word_t       data;
    // one-cycle pulse when data is valid
    logic              rdy;

    modport client (
        output req,
        output addr,
        input  we,
        input  data,
        input  rdy
    );

    modport server (
        input  req,
        input  addr,
        output we,
        output data,
        output rdy
    );

endinterface

`default_nettype wire

//--- src.f
logic/rom_geom_pkg.sv
logic/rom_types_pkg.sv
logic/slot_rd_if.sv
logic/rom_slot.sv
logic/rom_arbiter.sv
logic/rom_3slots.sv
test/sdram_model.sv
test/tb_rom_3slots.sv

//--- test/sdram_model.sv
// behavioral SDRAM read responder for the ROM port testbench, acks each request and returns data late
`timescale 1ns/1ps
`default_nettype none

module sdram_model #(
    parameter int          aw   = rom_geom_pkg::sdram_aw,
    parameter logic [31:0] seed = 32'h443d_a898
) (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               sdram_req,
    input  wire [aw-1:0]                      sdram_addr,
    output logic                              sdram_ack,
    output logic                              data_rdy,
    output rom_types_pkg::sdram_word_t        data_read
);
    logic [31:0] lcg_state;
    logic [aw-1:0] addr_q;
    logic        busy;
    int          delay;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // outputs change 10 ns after the rising edge, like the rest of the stimulus
    initial begin
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        busy      = 1'b0;
        delay     = 0;
        addr_q    = '0;
        lcg_state = seed;
        forever begin
            @(posedge clk);
            #10;
            sdram_ack = 1'b0;
            data_rdy  = 1'b0;
            if (rst) begin
                busy = 1'b0;
            end else if (busy) begin
                if (delay <= 1) begin
                    // word at address a is a times the key, 32-bit product
                    data_read = 32'(addr_q) * 32'h9e37_79b1;
                    data_rdy  = 1'b1;
                    busy      = 1'b0;
                end else begin
                    delay--;
                end
            end else if (sdram_req) begin
                sdram_ack = 1'b1;
                addr_q    = sdram_addr;
                lcg_state = lcg_next(lcg_state);
                // 1 to 6 cycles from ack to data
                delay     = 1 + int'(lcg_state[23:16] % 6);
                busy      = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_rom_3slots.sv
// testbench of the three-slot ROM port, runs directed and random reads against the SDRAM model
`timescale 1ns/1ps
`default_nettype none

module tb_rom_3slots;
    import rom_geom_pkg::*;
    import rom_types_pkg::*;

    localparam int          period  = 100;
    localparam int          n_tests = 5;
    localparam logic [31:0] mem_key = 32'h9e37_79b1;
    localparam logic [sdram_aw-1:0] slot_offset [n_slots] = '{'h0, 'h1000, 'h2000};

    logic                clk = 1'b0;
    logic                rst;
    logic [11:0]         slot_addr [n_slots];
    logic [n_slots-1:0]  slot_cs;
    logic [n_slots-1:0]  slot_ok;
    logic [7:0]          slot0_dout;
    logic [15:0]         slot1_dout;
    logic [31:0]         slot2_dout;
    logic                sdram_req;
    logic [sdram_aw-1:0] sdram_addr;
    logic                sdram_ack;
    logic                data_rdy;
    sdram_word_t         data_read;

    int                  errors = 0;
    int                  test_errors = 0;
    int                  req_edges = 0;
    logic                req_prev = 1'b0;
    logic [11:0]         addr_seen [n_slots];
    logic [sdram_aw-1:0] addr_log [$];
    logic [31:0]         rnd = 32'h443d_a898;

    always #(period / 2) clk = ~clk;

    rom_3slots #(
        .SDRAM_AW     (sdram_aw),
        .SLOT0_AW     (12),
        .SLOT1_AW     (12),
        .SLOT2_AW     (12),
        .SLOT0_OFFSET (slot_offset[0]),
        .SLOT1_OFFSET (slot_offset[1]),
        .SLOT2_OFFSET (slot_offset[2]),
        .slot0_t      (logic [7:0]),
        .slot1_t      (logic [15:0]),
        .slot2_t      (logic [31:0])
    ) rom_3slots_i (
        .clk        (clk),
        .rst        (rst),
        .slot0_addr (slot_addr[0]),
        .slot0_cs   (slot_cs[0]),
        .slot0_dout (slot0_dout),
        .slot0_ok   (slot_ok[0]),
        .slot1_addr (slot_addr[1]),
        .slot1_cs   (slot_cs[1]),
        .slot1_dout (slot1_dout),
        .slot1_ok   (slot_ok[1]),
        .slot2_addr (slot_addr[2]),
        .slot2_cs   (slot_cs[2]),
        .slot2_dout (slot2_dout),
        .slot2_ok   (slot_ok[2]),
        .sdram_req  (sdram_req),
        .sdram_addr (sdram_addr),
        .sdram_ack  (sdram_ack),
        .data_rdy   (data_rdy),
        .data_read  (data_read)
    );

    sdram_model #(.aw(sdram_aw), .seed(32'h443d_a898)) memory (
        .clk        (clk),
        .rst        (rst),
        .sdram_req  (sdram_req),
        .sdram_addr (sdram_addr),
        .sdram_ack  (sdram_ack),
        .data_rdy   (data_rdy),
        .data_read  (data_read)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // slot n holds items of 8 << n bits, so a word covers 4 >> n of them
    function automatic logic [sdram_aw-1:0] word_of(input int n, input logic [11:0] a);
        return slot_offset[n] + sdram_aw'(a >> (2 - n));
    endfunction

    function automatic logic [31:0] item_of(input int n, input logic [11:0] a);
        logic [31:0] word;
        word = 32'(word_of(n, a)) * mem_key;
        case (n)
            0: return (word >> (8 * a[1:0])) & 32'h0000_00ff;
            1: return (word >> (16 * a[0])) & 32'h0000_ffff;
            default: return word;
        endcase
    endfunction

    function automatic logic [31:0] dout_of(input int n);
        case (n)
            0: return 32'(slot0_dout);
            1: return 32'(slot1_dout);
            default: return slot2_dout;
        endcase
    endfunction

    task automatic note_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic value_error(input string sig, input logic [31:0] got, input logic [31:0] want);
        errors++;
        $display("error: %s got %h expected %h", sig, got, want);
    endtask

    task automatic finish_test(input string name);
        $display("test %s: %0d failed checks", name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic wait_ok(input int n);
        int cycles = 0;
        step();
        while (!slot_ok[n] && cycles < 60) begin
            step();
            cycles++;
        end
        if (!slot_ok[n]) begin
            note_failure($sformatf("slot%0d gave no ok within 60 cycles", n));
        end
    endtask

    task automatic read_item(input int n, input logic [11:0] a);
        slot_addr[n] = a;
        slot_cs[n]   = 1'b1;
        wait_ok(n);
    endtask

    // a cached word answers one clock after the new address is sampled
    task automatic check_hit(input int n, input logic [11:0] a);
        slot_addr[n] = a;
        step();
        assert (!slot_ok[n])
            else note_failure($sformatf("slot%0d ok stayed high across an address change", n));
        step();
        assert (slot_ok[n])
            else note_failure($sformatf("slot%0d gave no ok for a cached address", n));
    endtask

    // address each slot sampled at the last edge, which ok and dout refer to
    always @(posedge clk) begin
        for (int i = 0; i < n_slots; i++) begin
            addr_seen[i] <= slot_addr[i];
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            for (int i = 0; i < n_slots; i++) begin
                if (slot_ok[i]) begin
                    assert (dout_of(i) == item_of(i, addr_seen[i]))
                        else value_error($sformatf("slot%0d_dout", i), dout_of(i),
                                         item_of(i, addr_seen[i]));
                end
            end
            if (sdram_req && !req_prev) begin
                req_edges++;
                addr_log.push_back(sdram_addr);
            end
        end
        req_prev = sdram_req;
    end

    a_reset_quiet: assert property (@(negedge clk) rst |-> !sdram_req && slot_ok == '0)
        else note_failure("sdram_req or an ok output was high during reset");

    a_one_read: assert property (@(posedge clk) disable iff (rst) !(sdram_req && data_rdy))
        else note_failure("a new SDRAM request overlapped the return of the previous read");

    for (genvar g = 0; g < n_slots; g++) begin : g_cs_low
        a_cs_low: assert property (@(posedge clk) disable iff (rst) !slot_cs[g] |=> !slot_ok[g])
            else note_failure($sformatf("slot%0d ok rose after a cycle with cs low", g));
    end

    initial begin
        int                  cycles;
        int                  ok_cycles;
        int                  edges_before;
        logic [sdram_aw-1:0] order [4];
        rst     = 1'b1;
        slot_cs = '0;
        for (int i = 0; i < n_slots; i++) begin
            slot_addr[i] = '0;
        end
        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;

        repeat (3) step();
        assert (!sdram_req && slot_ok == '0)
            else note_failure("sdram_req or an ok output was high right after reset");
        finish_test("reset state");

        read_item(0, 12'h010);
        read_item(1, 12'h021);
        read_item(2, 12'h033);
        finish_test("single-slot reads");

        edges_before = req_edges;
        for (int i = 1; i < 4; i++) begin
            check_hit(0, 12'h010 + 12'(i));
        end
        check_hit(1, 12'h020);
        assert (req_edges == edges_before)
            else value_error("sdram_req rising edges", req_edges, edges_before);
        slot_cs = '0;
        step();
        finish_test("cache hits");

        // slot 2 owns a read while all three slots move to fresh words
        read_item(2, 12'h100);
        addr_log.delete();
        slot_addr[2] = 12'h102;
        step();
        cycles = 0;
        while (!sdram_req && cycles < 20) begin
            step();
            cycles++;
        end
        order = '{word_of(2, 12'h102), word_of(0, 12'h200), word_of(1, 12'h300),
                  word_of(2, 12'h101)};
        slot_addr[0] = 12'h200;
        slot_addr[1] = 12'h300;
        slot_addr[2] = 12'h101;
        slot_cs      = '1;
        cycles = 0;
        while (slot_ok != '1 && cycles < 200) begin
            step();
            cycles++;
        end
        assert (slot_ok == '1) else note_failure("not every slot gave ok after the priority reads");
        assert (addr_log.size() == 4)
            else value_error("sdram read count", addr_log.size(), 4);
        for (int i = 0; i < 4 && i < addr_log.size(); i++) begin
            assert (addr_log[i] == order[i])
                else value_error($sformatf("sdram_addr[%0d]", i), addr_log[i], order[i]);
        end
        slot_cs = '0;
        step();
        finish_test("priority");

        ok_cycles = 0;
        for (int c = 0; c < 200; c++) begin
            for (int i = 0; i < n_slots; i++) begin
                rnd = next_random(rnd);
                slot_cs[i] = rnd[31:29] != 3'd0;
                if (rnd[28:26] == 3'd0) begin
                    slot_addr[i] = {8'h0, rnd[18:15]};
                end
            end
            step();
            ok_cycles += $countones(slot_ok);
        end
        assert (ok_cycles > 0) else note_failure("no slot gave ok during random traffic");
        slot_cs = '0;
        repeat (10) step();
        finish_test("random traffic");

        $display("tests run: %0d, failed checks: %0d", n_tests, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(n_tests * 400 * period);
        $display("watchdog: no result after %0d cycles", n_tests * 400);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
